// File: src/wa_arb_pkg.sv
package wa_arb_pkg;

   // ------------------------------------------------------------
   // Sizes
   // ------------------------------------------------------------
   localparam int NUM_MASTERS  = 4;
   localparam int MASTER_IDX_W = $clog2(NUM_MASTERS);

   // Index of one master and one bit per master
   typedef logic [MASTER_IDX_W-1:0] master_idx_t;
   typedef logic [NUM_MASTERS-1:0]  master_vec_t;

   // AXI AWLOCK encoding, value 3 is reserved and handled as normal
   typedef enum logic [1:0] {
      LOCK_NORMAL = 2'd0,
      LOCK_EXCL   = 2'd1,
      LOCK_LOCKED = 2'd2
   } lock_t;

   // ------------------------------------------------------------
   // Request side
   // ------------------------------------------------------------
   typedef struct packed {
      logic  valid;
      lock_t lock;
   } aw_req_t;

   // Master 0 in the lowest slot
   typedef aw_req_t [NUM_MASTERS-1:0] aw_req_vec_t;

   // ------------------------------------------------------------
   // Arbiter state and status
   // ------------------------------------------------------------
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_NORMAL = 2'd1,
      ST_LOCKED = 2'd2
   } wr_state_t;

   typedef struct packed {
      master_vec_t grant;
      logic        lock_active;
      logic        normal_active;
   } arb_status_t;

   // Status while no master owns the port
   localparam arb_status_t STATUS_IDLE = '0;

endpackage

// File: src/wa_lock_tracker.sv
`timescale 1ns/1ps

module wa_lock_tracker (
   input  logic                     ACLK,
   input  logic                     aresetn,
   input  wa_arb_pkg::aw_req_vec_t  reqs,
   output wa_arb_pkg::master_vec_t  lock_released
);

   // ------------------------------------------------------------
   // Lock-release flags
   // ------------------------------------------------------------
   // A locked request arms the lock, a normal request releases it.
   // Exclusive and reserved lock types keep whatever was there.
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         lock_released <= '0;
      end else begin
         for (int i = 0; i < wa_arb_pkg::NUM_MASTERS; i++) begin
            if (reqs[i].valid) begin
               case (reqs[i].lock)
                  wa_arb_pkg::LOCK_LOCKED: begin
                     lock_released[i] <= 1'b0;
                  end
                  wa_arb_pkg::LOCK_NORMAL: begin
                     lock_released[i] <= 1'b1;
                  end
                  default: begin
                     lock_released[i] <= lock_released[i];
                  end
               endcase
            end
         end
      end
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------
   for (genvar gi = 0; gi < wa_arb_pkg::NUM_MASTERS; gi++) begin : g_flag_chk
      // A locked request may never be what releases the lock
      a_no_rise_on_locked : assert property (
         @(posedge ACLK) disable iff (!aresetn)
         (reqs[gi].valid && reqs[gi].lock == wa_arb_pkg::LOCK_LOCKED)
            |=> !$rose(lock_released[gi])
      );
   end

endmodule

// File: src/wa_priority_select.sv
`timescale 1ns/1ps

module wa_priority_select (
   input  wa_arb_pkg::aw_req_vec_t  reqs,
   input  wa_arb_pkg::master_idx_t  start_idx,
   output logic                     pick_valid,
   output wa_arb_pkg::master_idx_t  pick_idx,
   output logic                     pick_locked
);

   // Request valids, one bit per master
   wa_arb_pkg::master_vec_t                   req_valid;
   // Two copies back to back so a part select does the rotation
   logic [2*wa_arb_pkg::NUM_MASTERS-1:0]      req_dbl;
   // Bit k is the master k places after start_idx
   wa_arb_pkg::master_vec_t                   req_rot;
   // Distance from start_idx to the first requester
   wa_arb_pkg::master_idx_t                   offset;

   // ------------------------------------------------------------
   // Rotate so that start_idx lands on bit 0
   // ------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < wa_arb_pkg::NUM_MASTERS; i++) begin
         req_valid[i] = reqs[i].valid;
      end
   end

   assign req_dbl = {req_valid, req_valid};
   assign req_rot = req_dbl[start_idx +: wa_arb_pkg::NUM_MASTERS];

   // ------------------------------------------------------------
   // First requester after rotation
   // ------------------------------------------------------------
   // Scan downwards so the lowest set bit wins
   always_comb begin
      offset = '0;
      for (int k = wa_arb_pkg::NUM_MASTERS - 1; k >= 0; k--) begin
         if (req_rot[k]) begin
            offset = wa_arb_pkg::master_idx_t'(k);
         end
      end
   end

   assign pick_valid = |req_rot;

   // Index wraps naturally in MASTER_IDX_W bits
   assign pick_idx = start_idx + offset;

   // Only a LOCK_LOCKED request starts a locked ownership
   assign pick_locked = pick_valid && (reqs[pick_idx].lock == wa_arb_pkg::LOCK_LOCKED);

endmodule

// File: src/wa_arbiter_fsm.sv
`timescale 1ns/1ps

module wa_arbiter_fsm (
   input  logic                     ACLK,
   input  logic                     aresetn,
   input  wa_arb_pkg::master_vec_t  wr_end,
   input  wa_arb_pkg::master_vec_t  lock_released,
   input  logic                     pick_valid,
   input  wa_arb_pkg::master_idx_t  pick_idx,
   input  logic                     pick_locked,
   output wa_arb_pkg::master_idx_t  start_idx,
   output wa_arb_pkg::arb_status_t  status
);

   // Current and next ownership
   wa_arb_pkg::wr_state_t    state_q;
   wa_arb_pkg::wr_state_t    state_d;
   wa_arb_pkg::master_idx_t  owner_q;
   wa_arb_pkg::master_idx_t  owner_d;

   // Owner has let go of the port this cycle
   logic                     port_free;

   // ------------------------------------------------------------
   // Where the search for the next owner begins
   // ------------------------------------------------------------
   always_comb begin
      case (state_q)
         wa_arb_pkg::ST_NORMAL: begin
            start_idx = owner_q;
         end
         wa_arb_pkg::ST_LOCKED: begin
            // Released lock hands over to the next master first
            start_idx = owner_q + 1'b1;
         end
         default: begin
            start_idx = '0;
         end
      endcase
   end

   // ------------------------------------------------------------
   // Free condition
   // ------------------------------------------------------------
   always_comb begin
      case (state_q)
         wa_arb_pkg::ST_NORMAL: begin
            port_free = wr_end[owner_q];
         end
         wa_arb_pkg::ST_LOCKED: begin
            // Locked owner holds on until a normal request cleared its lock
            port_free = wr_end[owner_q] && lock_released[owner_q];
         end
         default: begin
            port_free = 1'b1;
         end
      endcase
   end

   // ------------------------------------------------------------
   // Next state and owner
   // ------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      owner_d = owner_q;
      if (port_free) begin
         if (pick_valid) begin
            owner_d = pick_idx;
            if (pick_locked) begin
               state_d = wa_arb_pkg::ST_LOCKED;
            end else begin
               state_d = wa_arb_pkg::ST_NORMAL;
            end
         end else begin
            // Nobody waiting, keep the last owner index
            state_d = wa_arb_pkg::ST_IDLE;
         end
      end
   end

   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         state_q <= wa_arb_pkg::ST_IDLE;
         owner_q <= '0;
      end else begin
         state_q <= state_d;
         owner_q <= owner_d;
      end
   end

   // ------------------------------------------------------------
   // Registered status, one edge behind the state
   // ------------------------------------------------------------
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         status <= wa_arb_pkg::STATUS_IDLE;
      end else begin
         if (state_q == wa_arb_pkg::ST_IDLE) begin
            status <= wa_arb_pkg::STATUS_IDLE;
         end else begin
            status.grant         <= wa_arb_pkg::master_vec_t'(1) << owner_q;
            status.lock_active   <= (state_q == wa_arb_pkg::ST_LOCKED);
            status.normal_active <= (state_q == wa_arb_pkg::ST_NORMAL);
         end
      end
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------
   a_grant_onehot0 : assert property (
      @(posedge ACLK) disable iff (!aresetn)
      $onehot0(status.grant)
   );

   a_active_exclusive : assert property (
      @(posedge ACLK) disable iff (!aresetn)
      !(status.lock_active && status.normal_active)
   );

   // Locked ownership only ends on a releasing write end
   a_locked_hold : assert property (
      @(posedge ACLK) disable iff (!aresetn)
      (state_q == wa_arb_pkg::ST_LOCKED && !(wr_end[owner_q] && lock_released[owner_q]))
         |=> (state_q == wa_arb_pkg::ST_LOCKED && $stable(owner_q))
   );

endmodule

// File: src/wa_arbiter.sv
`timescale 1ns/1ps

module wa_arbiter (
   input  logic                     ACLK,
   input  logic                     aresetn,
   input  wa_arb_pkg::aw_req_vec_t  reqs,
   input  wa_arb_pkg::master_vec_t  wr_end,
   output wa_arb_pkg::arb_status_t  status
);

   // ------------------------------------------------------------
   // Internal nets
   // ------------------------------------------------------------
   wa_arb_pkg::master_vec_t  lock_released;
   wa_arb_pkg::master_idx_t  start_idx;
   logic                     pick_valid;
   wa_arb_pkg::master_idx_t  pick_idx;
   logic                     pick_locked;

   // Lock-release flag per master
   wa_lock_tracker u_lock_tracker (
      .ACLK          (ACLK),
      .aresetn       (aresetn),
      .reqs          (reqs),
      .lock_released (lock_released)
   );

   // Rotating search, combinational
   wa_priority_select u_priority_select (
      .reqs        (reqs),
      .start_idx   (start_idx),
      .pick_valid  (pick_valid),
      .pick_idx    (pick_idx),
      .pick_locked (pick_locked)
   );

   // Ownership and registered status
   wa_arbiter_fsm u_arbiter_fsm (
      .ACLK          (ACLK),
      .aresetn       (aresetn),
      .wr_end        (wr_end),
      .lock_released (lock_released),
      .pick_valid    (pick_valid),
      .pick_idx      (pick_idx),
      .pick_locked   (pick_locked),
      .start_idx     (start_idx),
      .status        (status)
   );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic ACLK,
   output logic aresetn
);

   localparam int HALF_PERIOD_NS = 50;
   localparam int RESET_CYCLES   = 2;

   initial begin
      ACLK = 1'b0;
      forever #(HALF_PERIOD_NS) ACLK = ~ACLK;
   end

   // Release on a rising edge so the first active edge is the next one
   initial begin
      aresetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge ACLK);
      aresetn <= 1'b1;
   end

endmodule

// File: tests/tb_wa_arbiter.sv
`timescale 1ns/1ps

module tb_wa_arbiter;

   localparam int NUM_CYCLES   = 2000;
   localparam int CLK_PERIOD   = 100;
   localparam int SLACK_CYCLES = 10;

   logic                     ACLK;
   logic                     aresetn;
   wa_arb_pkg::aw_req_vec_t  reqs;
   wa_arb_pkg::master_vec_t  wr_end;
   wa_arb_pkg::arb_status_t  status;

   // Reference model state
   wa_arb_pkg::wr_state_t    m_state    = wa_arb_pkg::ST_IDLE;
   wa_arb_pkg::master_idx_t  m_owner    = '0;
   wa_arb_pkg::master_vec_t  m_flags    = '0;
   wa_arb_pkg::arb_status_t  exp_status = '0;

   logic [31:0]              rng_state  = 32'h5e5e9c0e;

   // Event counts for the end-of-run sanity check
   int                       locked_hold_cnt    = 0;
   int                       locked_release_cnt = 0;
   int                       normal_end_cnt     = 0;

   tb_clock_gen u_clock_gen (
      .ACLK    (ACLK),
      .aresetn (aresetn)
   );

   wa_arbiter u_wa_arbiter (
      .ACLK    (ACLK),
      .aresetn (aresetn),
      .reqs    (reqs),
      .wr_end  (wr_end),
      .status  (status)
   );

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] v;
      v = x;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   // First valid master, walking up from start and wrapping
   function automatic wa_arb_pkg::master_idx_t search_from(
      input  wa_arb_pkg::aw_req_vec_t r,
      input  wa_arb_pkg::master_idx_t start,
      output logic                    found
   );
      wa_arb_pkg::master_idx_t idx;
      wa_arb_pkg::master_idx_t result;
      found  = 1'b0;
      result = start;
      for (int k = 0; k < wa_arb_pkg::NUM_MASTERS; k++) begin
         idx = wa_arb_pkg::master_idx_t'((int'(start) + k) % wa_arb_pkg::NUM_MASTERS);
         if (!found && r[idx].valid) begin
            found  = 1'b1;
            result = idx;
         end
      end
      return result;
   endfunction

   function automatic wa_arb_pkg::arb_status_t status_for(
      input wa_arb_pkg::wr_state_t   st,
      input wa_arb_pkg::master_idx_t owner
   );
      wa_arb_pkg::arb_status_t s;
      s = '0;
      if (st != wa_arb_pkg::ST_IDLE) begin
         for (int i = 0; i < wa_arb_pkg::NUM_MASTERS; i++) begin
            s.grant[i] = (owner == i);
         end
         s.lock_active   = (st == wa_arb_pkg::ST_LOCKED);
         s.normal_active = (st == wa_arb_pkg::ST_NORMAL);
      end
      return s;
   endfunction

   task automatic check_value(
      input string       name,
      input logic [31:0] expected,
      input logic [31:0] actual
   );
      if (actual !== expected) begin
         $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // ------------------------------------------------------------
   // Reference model, one step per rising edge
   // ------------------------------------------------------------
   task automatic model_step();
      logic                    free;
      logic                    found;
      wa_arb_pkg::master_idx_t start;
      wa_arb_pkg::master_idx_t pick;
      wa_arb_pkg::master_vec_t flags_n;
      // Status register shows the state from before this edge
      exp_status = status_for(m_state, m_owner);
      case (m_state)
         wa_arb_pkg::ST_NORMAL: begin
            free  = wr_end[m_owner];
            start = m_owner;
            if (wr_end[m_owner]) begin
               normal_end_cnt++;
            end
         end
         wa_arb_pkg::ST_LOCKED: begin
            free  = wr_end[m_owner] && m_flags[m_owner];
            start = m_owner + 1'b1;
            if (wr_end[m_owner] && m_flags[m_owner]) begin
               locked_release_cnt++;
            end else if (wr_end[m_owner]) begin
               locked_hold_cnt++;
            end
         end
         default: begin
            free  = 1'b1;
            start = '0;
         end
      endcase
      pick = search_from(reqs, start, found);
      flags_n = m_flags;
      for (int i = 0; i < wa_arb_pkg::NUM_MASTERS; i++) begin
         if (reqs[i].valid && reqs[i].lock == wa_arb_pkg::LOCK_LOCKED) begin
            flags_n[i] = 1'b0;
         end else if (reqs[i].valid && reqs[i].lock == wa_arb_pkg::LOCK_NORMAL) begin
            flags_n[i] = 1'b1;
         end
      end
      if (free) begin
         if (found) begin
            m_owner = pick;
            if (reqs[pick].lock == wa_arb_pkg::LOCK_LOCKED) begin
               m_state = wa_arb_pkg::ST_LOCKED;
            end else begin
               m_state = wa_arb_pkg::ST_NORMAL;
            end
         end else begin
            m_state = wa_arb_pkg::ST_IDLE;
         end
      end
      m_flags = flags_n;
   endtask

   // ------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------
   // Waiting masters hold their request, the owner and idle masters draw new ones
   task automatic drive_stimulus();
      wa_arb_pkg::aw_req_vec_t next_reqs;
      wa_arb_pkg::master_vec_t next_end;
      logic                    granted;
      next_reqs = reqs;
      next_end  = '0;
      for (int i = 0; i < wa_arb_pkg::NUM_MASTERS; i++) begin
         granted = (m_state != wa_arb_pkg::ST_IDLE) && (m_owner == i);
         if (granted || !reqs[i].valid) begin
            rng_state         = xorshift32(rng_state);
            next_reqs[i].valid = rng_state[0];
            next_reqs[i].lock  = wa_arb_pkg::lock_t'(rng_state[5:4]);
         end
      end
      // Write end for the owner, about one cycle in four
      if (m_state != wa_arb_pkg::ST_IDLE) begin
         rng_state = xorshift32(rng_state);
         if (rng_state[9:8] == 2'b00) begin
            next_end[m_owner] = 1'b1;
         end
      end
      reqs   <= next_reqs;
      wr_end <= next_end;
   endtask

   always @(posedge ACLK) begin
      if (!aresetn) begin
         m_state    = wa_arb_pkg::ST_IDLE;
         m_owner    = '0;
         m_flags    = '0;
         exp_status = '0;
         reqs   <= '0;
         wr_end <= '0;
      end else begin
         model_step();
         drive_stimulus();
      end
   end

   // ------------------------------------------------------------
   // Checks on the falling edge
   // ------------------------------------------------------------
   initial begin
      @(posedge ACLK);
      forever begin
         @(negedge ACLK);
         check_value("status.grant one-hot", 32'd1, 32'($onehot0(status.grant)));
         check_value("status active flags together", 32'd0,
                     32'(status.lock_active & status.normal_active));
         check_value("status.grant", 32'(exp_status.grant), 32'(status.grant));
         check_value("status.lock_active", 32'(exp_status.lock_active),
                     32'(status.lock_active));
         check_value("status.normal_active", 32'(exp_status.normal_active),
                     32'(status.normal_active));
      end
   end

   // ------------------------------------------------------------
   // Run control
   // ------------------------------------------------------------
   initial begin
      reqs   = '0;
      wr_end = '0;
      @(posedge aresetn);
      repeat (NUM_CYCLES) @(posedge ACLK);
      @(negedge ACLK);
      #1;
      if (locked_hold_cnt > 0 && locked_release_cnt > 0 && normal_end_cnt > 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("Stimulus never reached a locked hold, a lock release or a normal write end");
         $display("Test failed");
         $fatal(1, "Incomplete stimulus");
      end
   end

   initial begin
      #((NUM_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
      $display("Timeout: the run did not finish within the expected number of cycles");
      $display("Test failed");
      $fatal(1, "Watchdog expired");
   end

endmodule

// File: vlog.f
src/wa_arb_pkg.sv
src/wa_lock_tracker.sv
src/wa_priority_select.sv
src/wa_arbiter_fsm.sv
src/wa_arbiter.sv
tests/tb_clock_gen.sv
tests/tb_wa_arbiter.sv

// File: Bender.yml
package:
  name: wa_arbiter

sources:
  # Package first, then leaf modules, then the top level
  - src/wa_arb_pkg.sv
  - src/wa_lock_tracker.sv
  - src/wa_priority_select.sv
  - src/wa_arbiter_fsm.sv
  - src/wa_arbiter.sv

  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_wa_arbiter.sv

# Top modules
#   RTL:       wa_arbiter
#   Testbench: tb_wa_arbiter
